// File: verilog/l3Ctrl_config.svh
/*
 * Layer-3 helper constants
 * ARP field codes as they appear in the little-endian buffer words,
 * fixed ARP frame words, counter widths and receive status bits
 */
`ifndef L3CTRL_CONFIG_SVH
`define L3CTRL_CONFIG_SVH

`define ARP_HW_ETHER		16'h0100		// Ethernet hardware type
`define ARP_PROTO_IPV4		16'h0008		// IPv4 protocol type
`define ARP_OP_REQUEST		16'h0100
`define ARP_OP_REPLY		16'h0200

`define ARP_HDR_TYPE		32'h01000608	// Hardware type over EtherType
`define ARP_HDR_LEN			32'h04060008	// Plen, Hlen, protocol
`define ARP_FRAME_LEN_WORD	32'h002A0000	// 42-byte frame header word
`define ARP_FRAME_WORDS		12

`define ARP_IDX_W			4				// Word index inside an ARP frame
`define WORD_CNT_W			15				// Words left in a received frame

`define RX_ERR_BITS			3				// Low status bits flag errors
`define RX_STATUS_ARP		9

`endif

// File: verilog/l3BufPkg.sv
/*
 * Buffer port types
 * Data words, lengths and status of the MAC receive buffer, and the
 * beat written into the transmit buffer
 */
package l3BufPkg;

	typedef logic [31:0] bufWord;
	typedef logic [15:0] bufLength;	// Frame length in bytes
	typedef logic [15:0] rxStatus;

	// One transmit buffer write
	typedef struct packed {
		logic	we;
		logic	start;		// First word of a frame
		logic	last;		// Frame end marker
		bufWord	data;
	} txBeat;

endpackage

// File: verilog/arpPkg.sv
/*
 * ARP types
 * Addresses, the action decided for a received frame, the fields
 * carried to the responder and the receive ownership states
 */
package arpPkg;

	typedef logic [47:0] macAddr;
	typedef logic [31:0] ipAddr;

	// Outcome of one parsed ARP frame
	typedef enum logic [1:0] {
		ACT_NONE,
		ACT_REPLY,		// Request for our IP
		ACT_LEARN		// Reply to our IP
	} arpAction;

	typedef struct packed {
		macAddr	senderMac;
		ipAddr	senderIp;
	} arpFields;

	// Who currently owns the receive side
	typedef enum logic [1:0] {
		OWN_IDLE,
		OWN_ARP,
		OWN_RESOLVE		// Outgoing request in progress
	} rxOwner;

endpackage

// File: verilog/rxDispatch.sv
/*
 * Receive dispatcher
 * Decides whether the frame at the head of the receive buffer is taken
 * by the ARP path or left to the host, and tracks ownership until the
 * internal user is finished
 */
`include "l3Ctrl_config.svh"

module rxDispatch (
	input	logic					CLK,
	input	logic					RST_N,
	input	logic					RX_BUFF_VALID,
	input	l3BufPkg::rxStatus		RX_BUFF_STATUS,
	input	logic					RX_BUFF_EMPTY,
	input	logic					ARPC_REQUEST,
	input	logic					ERX_BUFF_RE,
	input	logic					parseRead,
	input	logic					parseDone,
	input	logic					respDone,
	output	arpPkg::rxOwner			owner,
	output	logic					pickup,
	output	logic					RX_BUFF_RE,
	output	logic					ERX_BUFF_EMPTY,
	output	logic					ERX_BUFF_VALID,
	output	logic					ARPC_ENABLE
);

	logic	hostView;

	// Clean ARP frame at the head of the buffer
	assign pickup = RX_BUFF_VALID && (RX_BUFF_STATUS[`RX_ERR_BITS-1:0] == '0) &&
			RX_BUFF_STATUS[`RX_STATUS_ARP];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			owner <= arpPkg::OWN_IDLE;
		end else begin
			case (owner)
				arpPkg::OWN_IDLE: begin
					if (ARPC_REQUEST)
						owner <= arpPkg::OWN_RESOLVE;	// Request wins over pickup
					else if (pickup)
						owner <= arpPkg::OWN_ARP;
				end
				arpPkg::OWN_ARP: begin
					if (parseDone)
						owner <= arpPkg::OWN_IDLE;
				end
				arpPkg::OWN_RESOLVE: begin
					if (respDone)
						owner <= arpPkg::OWN_IDLE;
				end
				default: owner <= arpPkg::OWN_IDLE;
			endcase
		end
	end

	assign hostView = (owner == arpPkg::OWN_IDLE) && !pickup;

	assign RX_BUFF_RE		= ERX_BUFF_RE | parseRead;
	assign ERX_BUFF_EMPTY	= hostView ? RX_BUFF_EMPTY : 1'b1;	// Looks empty while owned
	assign ERX_BUFF_VALID	= hostView ? RX_BUFF_VALID : 1'b0;
	assign ARPC_ENABLE		= (owner == arpPkg::OWN_IDLE);

endmodule

// File: verilog/arpParser.sv
/*
 * ARP frame parser
 * Reads a received ARP frame one word per cycle, checks hardware type
 * and protocol, captures sender and target addresses, decides whether
 * to reply or learn, then drains the rest of the frame
 */
`include "l3Ctrl_config.svh"

module arpParser (
	input	logic					CLK,
	input	logic					RST_N,
	input	arpPkg::rxOwner			owner,
	input	l3BufPkg::bufWord		RX_BUFF_DATA,
	input	logic					RX_BUFF_EMPTY,
	input	l3BufPkg::bufLength		RX_BUFF_LENGTH,	// Bytes over all buffer words
	input	arpPkg::ipAddr			IP_ADDRESS,
	input	logic					frameBusy,
	output	logic					parseRead,
	output	arpPkg::arpAction		action,
	output	arpPkg::arpFields		fields,
	output	logic					parseDone
);

	typedef enum logic [2:0] {
		P_IDLE,
		P_READ,
		P_CHECK,
		P_DRAIN,
		P_WAIT,
		P_DONE
	} parseState;

	localparam logic [`ARP_IDX_W-1:0] W_TYPE		= 3;
	localparam logic [`ARP_IDX_W-1:0] W_PROTO	= 4;
	localparam logic [`ARP_IDX_W-1:0] W_OPCODE	= 5;
	localparam logic [`ARP_IDX_W-1:0] W_SMAC_HI	= 6;
	localparam logic [`ARP_IDX_W-1:0] W_SIP		= 7;
	localparam logic [`ARP_IDX_W-1:0] W_TIP_LO	= 9;
	localparam logic [`ARP_IDX_W-1:0] W_TIP_HI	= 10;

	parseState					state;
	logic [`ARP_IDX_W-1:0]		wordIdx;
	logic [`WORD_CNT_W-1:0]		wordsLeft;
	logic [16:0]				lenRound;
	logic						take;
	logic [15:0]				opcode;
	arpPkg::ipAddr				targetIp;

	assign lenRound = {1'b0, RX_BUFF_LENGTH} + 17'd3;	// Round up to whole words

	assign parseRead = ((state == P_READ) || (state == P_DRAIN)) &&
			(wordsLeft != '0) && !RX_BUFF_EMPTY;
	assign take = (state == P_READ) && parseRead;
	assign parseDone = (state == P_DONE);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state		<= P_IDLE;
			wordIdx		<= '0;
			wordsLeft	<= '0;
		end else begin
			case (state)
				P_IDLE: begin
					if (owner == arpPkg::OWN_ARP && !RX_BUFF_EMPTY) begin
						state		<= P_READ;
						wordIdx		<= '0;
						wordsLeft	<= lenRound[16:2];
					end
				end
				P_READ: begin
					if (!take) begin
						state <= P_DONE;	// Frame ran out early
					end else begin
						wordIdx		<= wordIdx + 1'b1;
						wordsLeft	<= wordsLeft - 1'b1;
						if (wordIdx == W_TYPE && RX_BUFF_DATA[31:16] != `ARP_HW_ETHER)
							state <= P_DRAIN;
						else if (wordIdx == W_PROTO && RX_BUFF_DATA[15:0] != `ARP_PROTO_IPV4)
							state <= P_DRAIN;
						else if (wordIdx == W_TIP_HI)
							state <= P_CHECK;
					end
				end
				P_CHECK: state <= P_DRAIN;
				P_DRAIN: begin
					if (parseRead)
						wordsLeft <= wordsLeft - 1'b1;
					else
						state <= P_WAIT;
				end
				P_WAIT: begin
					if (!frameBusy)
						state <= P_DONE;	// Let a pending reply finish first
				end
				default: state <= P_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (take) begin
			case (wordIdx)
				W_OPCODE: begin
					opcode						<= RX_BUFF_DATA[15:0];
					fields.senderMac[15:0]		<= RX_BUFF_DATA[31:16];
				end
				W_SMAC_HI:	fields.senderMac[47:16]	<= RX_BUFF_DATA;
				W_SIP:		fields.senderIp			<= RX_BUFF_DATA;
				W_TIP_LO:	targetIp[15:0]			<= RX_BUFF_DATA[31:16];
				W_TIP_HI:	targetIp[31:16]			<= RX_BUFF_DATA[15:0];
				default: ;
			endcase
		end
	end

	always_comb begin
		action = arpPkg::ACT_NONE;
		if (state == P_CHECK && targetIp == IP_ADDRESS) begin
			if (opcode == `ARP_OP_REQUEST)
				action = arpPkg::ACT_REPLY;
			else if (opcode == `ARP_OP_REPLY)
				action = arpPkg::ACT_LEARN;
		end
	end

endmodule

// File: verilog/arpResponder.sv
/*
 * ARP responder and resolver
 * Writes the 12-word ARP reply or broadcast request into the transmit
 * buffer, stalling on FULL, and keeps the single resolved cache entry
 */
`include "l3Ctrl_config.svh"

module arpResponder (
	input	logic					CLK,
	input	logic					RST_N,
	input	arpPkg::rxOwner			owner,
	input	arpPkg::arpAction		action,
	input	arpPkg::arpFields		fields,
	input	arpPkg::macAddr			MAC_ADDRESS,
	input	arpPkg::ipAddr			IP_ADDRESS,
	input	arpPkg::ipAddr			ARPC_IP_ADDRESS,
	input	logic					TX_BUFF_READY,
	input	logic					TX_BUFF_FULL,
	output	l3BufPkg::txBeat		arpBeat,
	output	logic					frameBusy,
	output	logic					respDone,
	output	logic					ARPC_VALID,
	output	arpPkg::macAddr			ARPC_MAC_ADDRESS
);

	typedef enum logic [1:0] {
		R_IDLE,
		R_WAIT,
		R_SEND,
		R_DONE
	} respState;

	localparam logic [`ARP_IDX_W-1:0] LAST_IDX	= `ARP_FRAME_WORDS - 1;
	localparam logic [`ARP_IDX_W-1:0] END_IDX	= `ARP_FRAME_WORDS;

	respState				state;
	logic [`ARP_IDX_W-1:0]	wordIdx;
	logic					isRequest;
	logic					sendWord;
	logic					beatWe;
	logic					beatStart;
	logic					beatLast;
	l3BufPkg::bufWord		beatData;
	l3BufPkg::bufWord		txWord;

	assign sendWord = (state == R_SEND) && (wordIdx != END_IDX) && !TX_BUFF_FULL;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state		<= R_IDLE;
			wordIdx		<= '0;
			isRequest	<= 1'b0;
			beatWe		<= 1'b0;
			beatStart	<= 1'b0;
			beatLast	<= 1'b0;
			ARPC_VALID	<= 1'b0;
		end else begin
			beatWe		<= sendWord;
			beatStart	<= sendWord && (wordIdx == '0);
			beatLast	<= sendWord && (wordIdx == LAST_IDX);
			case (state)
				R_IDLE: begin
					if (owner == arpPkg::OWN_RESOLVE) begin
						state		<= R_WAIT;
						isRequest	<= 1'b1;
						ARPC_VALID	<= 1'b0;	// Entry stale until the answer arrives
					end else if (owner == arpPkg::OWN_ARP && action == arpPkg::ACT_REPLY) begin
						state		<= R_WAIT;
						isRequest	<= 1'b0;
					end
				end
				R_WAIT: begin
					if (TX_BUFF_READY) begin
						state	<= R_SEND;
						wordIdx	<= '0;
					end
				end
				R_SEND: begin
					if (wordIdx == END_IDX)
						state <= R_DONE;
					else if (sendWord)
						wordIdx <= wordIdx + 1'b1;
				end
				default: state <= R_IDLE;
			endcase
			if (action == arpPkg::ACT_LEARN)
				ARPC_VALID <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (sendWord)
			beatData <= txWord;		// Held under back-pressure
		if (action == arpPkg::ACT_LEARN)
			ARPC_MAC_ADDRESS <= fields.senderMac;
	end

	// Reply goes back to the ARP sender, request is broadcast
	always_comb begin
		case (wordIdx)
			4'd0:	txWord = `ARP_FRAME_LEN_WORD;
			4'd1:	txWord = isRequest ? 32'hFFFF_FFFF : fields.senderMac[31:0];
			4'd2:	txWord = {MAC_ADDRESS[15:0],
					isRequest ? 16'hFFFF : fields.senderMac[47:32]};
			4'd3:	txWord = MAC_ADDRESS[47:16];
			4'd4:	txWord = `ARP_HDR_TYPE;
			4'd5:	txWord = `ARP_HDR_LEN;
			4'd6:	txWord = {MAC_ADDRESS[15:0], isRequest ? `ARP_OP_REQUEST : `ARP_OP_REPLY};
			4'd7:	txWord = MAC_ADDRESS[47:16];
			4'd8:	txWord = IP_ADDRESS;	// Target IP of a reply matched ours
			4'd9:	txWord = isRequest ? 32'h0 : fields.senderMac[31:0];
			4'd10:	txWord = isRequest ? {ARPC_IP_ADDRESS[15:0], 16'h0000} :
					{fields.senderIp[15:0], fields.senderMac[47:32]};
			4'd11:	txWord = {16'h0000,
					isRequest ? ARPC_IP_ADDRESS[31:16] : fields.senderIp[31:16]};
			default: txWord = '0;
		endcase
	end

	assign arpBeat.we		= beatWe;
	assign arpBeat.start	= beatStart;
	assign arpBeat.last		= beatLast;
	assign arpBeat.data		= beatData;

	assign frameBusy	= (state != R_IDLE);
	assign respDone		= (state == R_DONE);	// Cycle after the last word

endmodule

// File: verilog/txMerge.sv
/*
 * Transmit merge
 * Combines the internal ARP beats with host writes into the transmit
 * buffer and hides transmit-ready from the host while ARP is busy
 */
module txMerge (
	input	l3BufPkg::txBeat		arpBeat,
	input	arpPkg::rxOwner			owner,
	input	logic					pickup,
	input	logic					ETX_BUFF_WE,
	input	logic					ETX_BUFF_START,
	input	logic					ETX_BUFF_END,
	input	l3BufPkg::bufWord		ETX_BUFF_DATA,
	input	logic					TX_BUFF_READY,
	input	logic					TX_BUFF_FULL,
	output	logic					TX_BUFF_WE,
	output	logic					TX_BUFF_START,
	output	logic					TX_BUFF_END,
	output	l3BufPkg::bufWord		TX_BUFF_DATA,
	output	logic					ETX_BUFF_READY,
	output	logic					ETX_BUFF_FULL
);

	assign TX_BUFF_WE		= arpBeat.we | ETX_BUFF_WE;
	assign TX_BUFF_START	= arpBeat.start | ETX_BUFF_START;
	assign TX_BUFF_END		= arpBeat.last | ETX_BUFF_END;
	assign TX_BUFF_DATA		= arpBeat.we ? arpBeat.data : ETX_BUFF_DATA;	// Internal word first

	// Host may only start a frame while nothing internal is pending
	assign ETX_BUFF_READY	= (owner == arpPkg::OWN_IDLE && !pickup) ? TX_BUFF_READY : 1'b0;
	assign ETX_BUFF_FULL	= TX_BUFF_FULL;

endmodule

// File: verilog/l3Ctrl.sv
/*
 * Layer-3 helper top level
 * Sits between the MAC buffers and the host, answering ARP requests for
 * our IP, resolving one IP on request and passing other traffic through
 */
module l3Ctrl (
	input	logic					CLK,
	input	logic					RST_N,

	output	logic					RX_BUFF_RE,		// Receive buffer, show-ahead
	input	l3BufPkg::bufWord		RX_BUFF_DATA,
	input	logic					RX_BUFF_EMPTY,
	input	logic					RX_BUFF_VALID,
	input	l3BufPkg::bufLength		RX_BUFF_LENGTH,
	input	l3BufPkg::rxStatus		RX_BUFF_STATUS,

	output	logic					TX_BUFF_WE,
	output	logic					TX_BUFF_START,
	output	logic					TX_BUFF_END,
	output	l3BufPkg::bufWord		TX_BUFF_DATA,
	input	logic					TX_BUFF_READY,
	input	logic					TX_BUFF_FULL,

	input	logic					ERX_BUFF_RE,	// Host receive side
	output	l3BufPkg::bufWord		ERX_BUFF_DATA,
	output	logic					ERX_BUFF_EMPTY,
	output	logic					ERX_BUFF_VALID,
	output	l3BufPkg::bufLength		ERX_BUFF_LENGTH,
	output	l3BufPkg::rxStatus		ERX_BUFF_STATUS,

	input	logic					ETX_BUFF_WE,	// Host transmit side
	input	logic					ETX_BUFF_START,
	input	logic					ETX_BUFF_END,
	input	l3BufPkg::bufWord		ETX_BUFF_DATA,
	output	logic					ETX_BUFF_READY,
	output	logic					ETX_BUFF_FULL,

	input	arpPkg::macAddr			MAC_ADDRESS,
	input	arpPkg::ipAddr			IP_ADDRESS,

	output	logic					ARPC_ENABLE,
	input	logic					ARPC_REQUEST,
	input	arpPkg::ipAddr			ARPC_IP_ADDRESS,
	output	logic					ARPC_VALID,
	output	arpPkg::macAddr			ARPC_MAC_ADDRESS
);

	arpPkg::rxOwner		owner;
	logic				pickup;
	logic				parseRead;
	logic				parseDone;
	arpPkg::arpAction	action;
	arpPkg::arpFields	fields;
	logic				frameBusy;
	logic				respDone;
	l3BufPkg::txBeat	arpBeat;

	// Host always sees the head frame's data and descriptors
	assign ERX_BUFF_DATA	= RX_BUFF_DATA;
	assign ERX_BUFF_LENGTH	= RX_BUFF_LENGTH;
	assign ERX_BUFF_STATUS	= RX_BUFF_STATUS;

	rxDispatch i_rxDispatch (.*);

	arpParser i_arpParser (.*);

	arpResponder i_arpResponder (.*);

	txMerge i_txMerge (.*);

endmodule

// File: sim/l3CtrlTb.sv
/*
 * Layer-3 helper testbench
 * Directed tests for the ARP reply, foreign and host frames, address
 * resolution, transmit back-pressure and host transmit pass-through
 */
module l3CtrlTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TESTS		= 5;
	localparam int CYCLES_PER_TEST	= 600;
	localparam int TIMEOUT_CYCLES	= NUM_TESTS * CYCLES_PER_TEST;
	localparam int ARP_RX_WORDS		= 16;			// Padded ARP frame in the buffer
	localparam logic [15:0] OP_REQUEST	= 16'h0100;
	localparam logic [15:0] OP_REPLY	= 16'h0200;
	localparam logic [47:0] OWN_MAC		= 48'h0A1B_2C3D_4E5F;
	localparam logic [31:0] OWN_IP		= 32'hC0A8_0164;
	localparam logic [47:0] PEER_MAC	= 48'h0011_2233_4455;
	localparam logic [31:0] PEER_IP		= 32'hC0A8_010A;
	localparam logic [31:0] OTHER_IP	= 32'hC0A8_0199;
	localparam logic [31:0] RESOLVE_IP	= 32'hC0A8_0122;
	localparam logic [47:0] LEARN_MAC	= 48'h6655_4433_2211;

	logic			CLK, RST_N;
	logic			RX_BUFF_RE, RX_BUFF_EMPTY, RX_BUFF_VALID;
	logic [31:0]	RX_BUFF_DATA;
	logic [15:0]	RX_BUFF_LENGTH, RX_BUFF_STATUS;
	logic			TX_BUFF_WE, TX_BUFF_START, TX_BUFF_END, TX_BUFF_READY, TX_BUFF_FULL;
	logic [31:0]	TX_BUFF_DATA;
	logic			ERX_BUFF_RE, ERX_BUFF_EMPTY, ERX_BUFF_VALID;
	logic [31:0]	ERX_BUFF_DATA;
	logic [15:0]	ERX_BUFF_LENGTH, ERX_BUFF_STATUS;
	logic			ETX_BUFF_WE, ETX_BUFF_START, ETX_BUFF_END, ETX_BUFF_READY, ETX_BUFF_FULL;
	logic [31:0]	ETX_BUFF_DATA;
	logic [47:0]	MAC_ADDRESS, ARPC_MAC_ADDRESS;
	logic [31:0]	IP_ADDRESS, ARPC_IP_ADDRESS;
	logic			ARPC_ENABLE, ARPC_REQUEST, ARPC_VALID;

	logic [31:0]		rxMem [0:31];
	int					rxPtr, rxCount;
	l3BufPkg::txBeat	txLog[$];
	l3BufPkg::txBeat	seenBeat;
	logic				prevFull;
	int					cycleCount, fullCycles, errorCount;

	l3Ctrl i_l3Ctrl (.*);

	always #5 CLK = ~CLK;

	// Show-ahead receive buffer holding one frame
	assign RX_BUFF_EMPTY	= (rxPtr >= rxCount);
	assign RX_BUFF_VALID	= !RX_BUFF_EMPTY;
	assign RX_BUFF_DATA		= RX_BUFF_EMPTY ? 32'h0 : rxMem[rxPtr];

	always @(posedge CLK) begin
		if (RX_BUFF_RE && !RX_BUFF_EMPTY)
			rxPtr <= rxPtr + 1;
	end

	task automatic checkEq(input string testName, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			errorCount++;
			$display("[ERROR] %s: expected 0x%0h, actual 0x%0h", testName, expected, actual);
			$display("Checks failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	// Log every transmit write; a write must follow a cycle with FULL low
	always @(posedge CLK) begin
		if (RST_N && TX_BUFF_WE) begin
			checkEq("txWriteAfterFull", 64'd0, {63'd0, prevFull});
			seenBeat.we		= 1'b1;
			seenBeat.start	= TX_BUFF_START;
			seenBeat.last	= TX_BUFF_END;
			seenBeat.data	= TX_BUFF_DATA;
			txLog.push_back(seenBeat);
		end
		prevFull = TX_BUFF_FULL;
	end

	always @(posedge CLK) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks failed");
			$fatal(1, "Timeout");
		end
	end

	task automatic nextCycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic loadArpFrame(input logic [15:0] opcode, input logic [47:0] senderMac,
			input logic [31:0] senderIp, input logic [31:0] targetIp);
		for (int i = 0; i < ARP_RX_WORDS; i++)
			rxMem[i] = {16'hA5A5, 16'(i)};				// Padding past the ARP body
		rxMem[0]	= {16'(ARP_RX_WORDS * 4), 16'h0000};
		rxMem[1]	= {senderMac[15:0], 16'hFFFF};
		rxMem[2]	= senderMac[47:16];
		rxMem[3]	= 32'h0100_0608;					// Hardware type over EtherType
		rxMem[4]	= 32'h0406_0008;
		rxMem[5]	= {senderMac[15:0], opcode};
		rxMem[6]	= senderMac[47:16];
		rxMem[7]	= senderIp;
		rxMem[8]	= 32'h0;
		rxMem[9]	= {targetIp[15:0], 16'h0000};
		rxMem[10]	= {16'h0000, targetIp[31:16]};
		RX_BUFF_LENGTH	= 16'(ARP_RX_WORDS * 4);
		RX_BUFF_STATUS	= 16'h0200;						// ARP flag, no errors
		rxPtr			= 0;
		rxCount			= ARP_RX_WORDS;
	endtask

	// Ownership is taken and then handed back to idle
	task automatic waitArpFinished(input bit randomFull);
		while (ARPC_ENABLE) begin
			TX_BUFF_FULL = randomFull ? 1'($urandom_range(0, 1)) : 1'b0;
			fullCycles += TX_BUFF_FULL;
			nextCycle();
		end
		while (!ARPC_ENABLE) begin
			checkEq("owned.erxValid", 0, ERX_BUFF_VALID);	// Host side masked
			checkEq("owned.erxEmpty", 1, ERX_BUFF_EMPTY);
			checkEq("owned.etxReady", 0, ETX_BUFF_READY);
			TX_BUFF_FULL = randomFull ? 1'($urandom_range(0, 1)) : 1'b0;
			fullCycles += TX_BUFF_FULL;
			nextCycle();
		end
		TX_BUFF_FULL = 1'b0;
		nextCycle();
	endtask

	task automatic issueArpRequest();
		ARPC_REQUEST = 1'b1;
		nextCycle();
		ARPC_REQUEST = 1'b0;
		waitArpFinished(1'b0);
	endtask

	function automatic logic [31:0] expectedTxWord(input bit isRequest, input int idx,
			input logic [47:0] peerMac, input logic [31:0] peerIp);
		case (idx)
			0:	return 32'h002A_0000;
			1:	return isRequest ? 32'hFFFF_FFFF : peerMac[31:0];
			2:	return {OWN_MAC[15:0], isRequest ? 16'hFFFF : peerMac[47:32]};
			3:	return OWN_MAC[47:16];
			4:	return 32'h0100_0608;
			5:	return 32'h0406_0008;
			6:	return {OWN_MAC[15:0], isRequest ? OP_REQUEST : OP_REPLY};
			7:	return OWN_MAC[47:16];
			8:	return OWN_IP;
			9:	return isRequest ? 32'h0 : peerMac[31:0];
			10:	return isRequest ? {peerIp[15:0], 16'h0000} : {peerIp[15:0], peerMac[47:32]};
			default: return {16'h0000, peerIp[31:16]};
		endcase
	endfunction

	task automatic checkTxFrame(input string testName, input bit isRequest,
			input logic [47:0] peerMac, input logic [31:0] peerIp);
		checkEq({testName, ".words"}, 64'd12, txLog.size());
		for (int i = 0; i < 12; i++) begin
			checkEq({testName, ".data"}, expectedTxWord(isRequest, i, peerMac, peerIp),
					txLog[i].data);
			checkEq({testName, ".start"}, (i == 0), txLog[i].start);
			checkEq({testName, ".end"}, (i == 11), txLog[i].last);
		end
	endtask

	task automatic resetState();
		checkEq("reset.txWe", 0, TX_BUFF_WE);
		checkEq("reset.rxRe", 0, RX_BUFF_RE);
		checkEq("reset.arpcValid", 0, ARPC_VALID);
		checkEq("reset.arpcEnable", 1, ARPC_ENABLE);
		TX_BUFF_READY = 1'b0;
		#1 checkEq("reset.etxReady", 0, ETX_BUFF_READY);
		TX_BUFF_READY = 1'b1;
		#1 checkEq("reset.etxReady", 1, ETX_BUFF_READY);
		TX_BUFF_FULL = 1'b1;
		#1 checkEq("reset.etxFull", 1, ETX_BUFF_FULL);
		TX_BUFF_FULL = 1'b0;
		#1 checkEq("reset.etxFull", 0, ETX_BUFF_FULL);
		nextCycle();
	endtask

	task automatic arpReply(input bit randomFull);
		string testName;
		if (randomFull)
			testName = "backPressure";
		else
			testName = "reply";
		txLog.delete();
		fullCycles = 0;
		loadArpFrame(OP_REQUEST, PEER_MAC, PEER_IP, OWN_IP);
		waitArpFinished(randomFull);
		checkEq({testName, ".consumed"}, ARP_RX_WORDS, rxPtr);
		checkTxFrame(testName, 1'b0, PEER_MAC, PEER_IP);
		if (randomFull)
			checkEq("backPressure.fullSeen", 1, fullCycles != 0);
	endtask

	task automatic foreignAndHostFrames();
		txLog.delete();
		loadArpFrame(OP_REQUEST, PEER_MAC, PEER_IP, OTHER_IP);
		waitArpFinished(1'b0);
		checkEq("foreign.consumed", ARP_RX_WORDS, rxPtr);
		checkEq("foreign.writes", 0, txLog.size());
		for (int i = 0; i < 6; i++)
			rxMem[i] = {16'h5A00, 16'(i * 7 + 1)};
		RX_BUFF_LENGTH = 16'd24;
		RX_BUFF_STATUS = 16'h0100;						// Not ARP, stays with the host
		rxPtr = 0;
		rxCount = 6;
		while (!RX_BUFF_EMPTY) begin
			ERX_BUFF_RE = 1'($urandom_range(0, 1));
			#1;
			checkEq("host.valid", RX_BUFF_VALID, ERX_BUFF_VALID);
			checkEq("host.empty", 0, ERX_BUFF_EMPTY);
			checkEq("host.re", ERX_BUFF_RE, RX_BUFF_RE);
			checkEq("host.data", rxMem[rxPtr], ERX_BUFF_DATA);
			checkEq("host.length", 16'd24, ERX_BUFF_LENGTH);
			checkEq("host.status", 16'h0100, ERX_BUFF_STATUS);
			checkEq("host.idle", 1, ARPC_ENABLE);
			nextCycle();
		end
		ERX_BUFF_RE = 1'b0;
		nextCycle();
		checkEq("host.writes", 0, txLog.size());
	endtask

	task automatic resolveAddress();
		txLog.delete();
		issueArpRequest();
		checkTxFrame("resolve.request", 1'b1, 48'h0, RESOLVE_IP);
		txLog.delete();
		loadArpFrame(OP_REPLY, LEARN_MAC, PEER_IP, OWN_IP);
		waitArpFinished(1'b0);
		checkEq("resolve.consumed", ARP_RX_WORDS, rxPtr);
		checkEq("resolve.writes", 0, txLog.size());
		checkEq("resolve.valid", 1, ARPC_VALID);
		checkEq("resolve.mac", LEARN_MAC, ARPC_MAC_ADDRESS);
		txLog.delete();
		issueArpRequest();							// New request makes the entry stale
		checkTxFrame("resolve.again", 1'b1, 48'h0, RESOLVE_IP);
		checkEq("resolve.validLow", 0, ARPC_VALID);
	endtask

	task automatic hostTransmit();
		txLog.delete();
		for (int i = 0; i < 4; i++) begin
			ETX_BUFF_WE		= 1'b1;
			ETX_BUFF_START	= (i == 0);
			ETX_BUFF_END	= (i == 3);
			ETX_BUFF_DATA	= {16'hBEEF, 16'(i * 3 + 2)};
			@(posedge CLK);
			checkEq("hostTx.ready", 1, ETX_BUFF_READY);
			checkEq("hostTx.we", 1, TX_BUFF_WE);
			checkEq("hostTx.start", ETX_BUFF_START, TX_BUFF_START);
			checkEq("hostTx.end", ETX_BUFF_END, TX_BUFF_END);
			checkEq("hostTx.data", ETX_BUFF_DATA, TX_BUFF_DATA);
			#1;
		end
		ETX_BUFF_WE		= 1'b0;
		ETX_BUFF_START	= 1'b0;
		ETX_BUFF_END	= 1'b0;
		nextCycle();
		checkEq("hostTx.writes", 4, txLog.size());
	endtask

	initial begin
		void'($urandom(12));
		CLK = 1'b0;
		RST_N = 1'b0;
		rxPtr = 0;
		rxCount = 0;
		for (int i = 0; i < 32; i++)
			rxMem[i] = 32'hC0DE_0000 | i;
		RX_BUFF_LENGTH = '0;
		RX_BUFF_STATUS = '0;
		TX_BUFF_READY = 1'b1;
		TX_BUFF_FULL = 1'b0;
		ERX_BUFF_RE = 1'b0;
		{ETX_BUFF_WE, ETX_BUFF_START, ETX_BUFF_END} = '0;
		ETX_BUFF_DATA = '0;
		MAC_ADDRESS = OWN_MAC;
		IP_ADDRESS = OWN_IP;
		ARPC_REQUEST = 1'b0;
		ARPC_IP_ADDRESS = RESOLVE_IP;
		prevFull = 1'b0;
		cycleCount = 0;
		fullCycles = 0;
		errorCount = 0;
		repeat (8) @(posedge CLK);
		#1 RST_N = 1'b1;
		resetState();
		arpReply(1'b0);
		foreignAndHostFrames();
		resolveAddress();
		arpReply(1'b1);
		hostTransmit();
		if (errorCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: l3Ctrl.f
+incdir+verilog
verilog/l3BufPkg.sv
verilog/arpPkg.sv
verilog/rxDispatch.sv
verilog/arpParser.sv
verilog/arpResponder.sv
verilog/txMerge.sv
verilog/l3Ctrl.sv
sim/l3CtrlTb.sv
